/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_addr_t;

    // instruction class, ir[31:28]
    typedef enum logic [3:0] {
        T_INH    = 4'h0,
        T_CMP    = 4'h3,
        T_ALU    = 4'h9,
        T_LDI    = 4'ha,
        T_LOAD   = 4'hb,
        T_STORE  = 4'hc,
        T_BRANCH = 4'hd
    } itype_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'h0,
        ALU_SUB = 3'h1,
        ALU_AND = 3'h2,
        ALU_OR  = 3'h3,
        ALU_XOR = 3'h4,
        ALU_SHL = 3'h5,
        ALU_SHR = 3'h6  // logical
    } alu_op_e;

    // codes not listed never branch
    typedef enum logic [3:0] {
        BRA  = 4'h0,
        BEQ  = 4'h1,
        BNE  = 4'h2,
        BGE  = 4'h5,
        BLT  = 4'h7,
        BGEU = 4'h8,
        BLTU = 4'h9
    } branch_op_e;

    typedef struct packed {
        logic ltu;
        logic lt;
        logic eq;
    } flags_t;

    typedef enum logic [1:0] {ALU2_B, ALU2_SVAL} alu2_sel_e;
    typedef enum logic [1:0] {REG_ALU, REG_MDR, REG_UVAL} reg_src_e;
    typedef enum logic [1:0] {MDR_KEEP, MDR_BUS, MDR_ALU, MDR_A} mdr_sel_e;
    typedef enum logic [1:0] {MAR_KEEP, MAR_ALU} mar_sel_e;
    typedef enum logic [1:0] {PC_KEEP, PC_NEXT, PC_REL} pc_sel_e;

    typedef enum logic [4:0] {
        S_RESET, S_FETCH, S_FETCH2, S_EVAL, S_LDI,
        S_ALU, S_ALU2, S_ALU3, S_CMP, S_CMP2, S_CMP3,
        S_BRANCH, S_LOAD, S_LOAD2, S_LOAD3, S_LOADD,
        S_STORE, S_STORE2, S_STORE3, S_STORE4,
        S_MDR2RA, S_TERM, S_HALT
    } state_e;

    typedef struct packed {
        logic       ir_write;
        logic       a_write;
        logic       b_write;
        logic       reg_write;
        logic       ccr_write;
        logic       addr_mar;  // bus address from MAR, else PC
        alu_op_e    alu_func;
        alu2_sel_e  alu2sel;
        reg_src_e   regsel;
        mdr_sel_e   mdrsel;
        mar_sel_e   marsel;
        pc_sel_e    pcsel;
        reg_addr_t  rd_addr1;
        reg_addr_t  rd_addr2;
        reg_addr_t  wr_addr;
    } ctrl_t;

    typedef struct packed {
        logic  cyc;
        logic  we;
        word_t adr;
        word_t dat;
    } bus_req_t;

    function automatic reg_addr_t ir_ra(word_t ir);
        return ir[23:20];
    endfunction

    function automatic reg_addr_t ir_rb(word_t ir);
        return ir[19:16];
    endfunction

    function automatic reg_addr_t ir_rc(word_t ir);
        return ir[15:12];
    endfunction

    function automatic word_t ir_uval(word_t ir);
        return {17'h0, ir[15:1]};
    endfunction

    function automatic word_t ir_sval(word_t ir);
        return {{17{ir[15]}}, ir[15:1]};
    endfunction

endpackage

`default_nettype wire

/* cpu_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_alu import cpu_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e func,
    output word_t   result,
    output flags_t  flags
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (func)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SHL: result = a << shamt;
            ALU_SHR: result = a >> shamt;
            default: result = '0;
        endcase
    end

    // compare view of a - b, independent of func
    assign flags.eq  = (a == b);
    assign flags.lt  = ($signed(a) < $signed(b));
    assign flags.ltu = (a < b);

endmodule

`default_nettype wire

/* cpu_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_datapath import cpu_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic   clk_i,
    input  logic   rst_i,
    input  ctrl_t  ctrl,
    input  word_t  bus_rdata,
    input  logic   bus_ack,
    output word_t  ir,
    output flags_t ccr,
    output word_t  bus_adr,
    output word_t  bus_wdat
);

    word_t  regs [16];  // r15 is sp
    word_t  a_q;
    word_t  b_q;
    word_t  mar_q;
    word_t  mdr_q;
    word_t  pc_q;
    word_t  ir_q;
    flags_t ccr_q;

    word_t  alu_b;
    word_t  alu_result;
    flags_t alu_flags;
    word_t  reg_wdata;
    word_t  sval;

    assign sval  = ir_sval(ir_q);
    assign alu_b = (ctrl.alu2sel == ALU2_SVAL) ? sval : b_q;

    cpu_alu i_alu (
        .a      (a_q),
        .b      (alu_b),
        .func   (ctrl.alu_func),
        .result (alu_result),
        .flags  (alu_flags)
    );

    always_comb begin
        case (ctrl.regsel)
            REG_MDR:  reg_wdata = mdr_q;
            REG_UVAL: reg_wdata = ir_uval(ir_q);
            default:  reg_wdata = alu_result;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (ctrl.reg_write) begin
            regs[ctrl.wr_addr] <= reg_wdata;
        end
    end

    // operand latches and memory interface registers
    always_ff @(posedge clk_i) begin
        if (ctrl.a_write) begin
            a_q <= regs[ctrl.rd_addr1];
        end
        if (ctrl.b_write) begin
            b_q <= regs[ctrl.rd_addr2];
        end
        if (ctrl.marsel == MAR_ALU) begin
            mar_q <= alu_result;
        end
        case (ctrl.mdrsel)
            MDR_BUS: begin
                if (bus_ack) begin
                    mdr_q <= bus_rdata;
                end
            end
            MDR_ALU: mdr_q <= alu_result;
            MDR_A:   mdr_q <= a_q;
            default: mdr_q <= mdr_q;
        endcase
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            pc_q <= RESET_PC;
        end else begin
            case (ctrl.pcsel)
                PC_NEXT: pc_q <= pc_q + 32'd4;
                PC_REL:  pc_q <= pc_q + {sval[29:0], 2'b00};  // word offset
                default: pc_q <= pc_q;
            endcase
        end
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            ir_q  <= '0;
            ccr_q <= '0;
        end else begin
            if (ctrl.ir_write && bus_ack) begin
                ir_q <= bus_rdata;
            end
            if (ctrl.ccr_write) begin
                ccr_q <= alu_flags;
            end
        end
    end

    assign ir       = ir_q;
    assign ccr      = ccr_q;
    assign bus_adr  = ctrl.addr_mar ? mar_q : pc_q;
    assign bus_wdat = mdr_q;

endmodule

`default_nettype wire

/* cpu_control.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_control import cpu_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_i,
    input  word_t  ir,
    input  flags_t ccr,
    input  logic   bus_ack,
    output ctrl_t  ctrl,
    output logic   bus_cyc,
    output logic   bus_we,
    output logic   halt
);

    state_e     state;
    state_e     state_next;
    itype_e     ir_type;
    logic [3:0] ir_op;
    logic       br_taken;

    assign ir_type = itype_e'(ir[31:28]);
    assign ir_op   = ir[27:24];
    assign halt    = (state == S_HALT);

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state <= S_RESET;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (branch_op_e'(ir_op))
            BRA:     br_taken = 1'b1;
            BEQ:     br_taken = ccr.eq;
            BNE:     br_taken = ~ccr.eq;
            BLT:     br_taken = ccr.lt;
            BGE:     br_taken = ~ccr.lt;
            BLTU:    br_taken = ccr.ltu;
            BGEU:    br_taken = ~ccr.ltu;
            default: br_taken = 1'b0;  // never
        endcase
    end

    always_comb begin
        state_next     = state;
        ctrl.ir_write  = 1'b0;
        ctrl.a_write   = 1'b0;
        ctrl.b_write   = 1'b0;
        ctrl.reg_write = 1'b0;
        ctrl.ccr_write = 1'b0;
        ctrl.addr_mar  = 1'b0;
        ctrl.alu_func  = ALU_ADD;
        ctrl.alu2sel   = ALU2_B;
        ctrl.regsel    = REG_ALU;
        ctrl.mdrsel    = MDR_KEEP;
        ctrl.marsel    = MAR_KEEP;
        ctrl.pcsel     = PC_KEEP;
        ctrl.rd_addr1  = ir_ra(ir);
        ctrl.rd_addr2  = ir_rb(ir);
        ctrl.wr_addr   = ir_ra(ir);
        bus_cyc        = 1'b0;
        bus_we         = 1'b0;

        case (state)
            S_RESET: state_next = S_FETCH;
            S_FETCH: begin
                bus_cyc       = 1'b1;
                ctrl.ir_write = 1'b1;  // ir latched on ack
                if (bus_ack) begin
                    state_next = S_FETCH2;
                end
            end
            S_FETCH2: begin
                ctrl.pcsel = PC_NEXT;
                state_next = S_EVAL;
            end
            S_EVAL: begin
                case (ir_type)
                    T_INH:    state_next = (ir_op == 4'h0) ? S_FETCH : S_HALT;
                    T_LDI:    state_next = S_LDI;
                    T_ALU:    state_next = S_ALU;
                    T_CMP:    state_next = S_CMP;
                    T_BRANCH: state_next = S_BRANCH;
                    T_LOAD:   state_next = S_LOAD;
                    T_STORE:  state_next = S_STORE;
                    default:  state_next = S_HALT;
                endcase
            end
            S_LDI: begin
                ctrl.regsel    = REG_UVAL;
                ctrl.reg_write = 1'b1;
                state_next     = S_FETCH;
            end
            S_ALU: begin
                ctrl.rd_addr1 = ir_rb(ir);
                ctrl.rd_addr2 = ir_rc(ir);
                ctrl.a_write  = 1'b1;  // a <= rb
                ctrl.b_write  = 1'b1;  // b <= rc
                state_next    = S_ALU2;
            end
            S_ALU2: begin
                ctrl.alu_func = alu_op_e'(ir_op[2:0]);
                state_next    = S_ALU3;
            end
            S_ALU3: begin
                ctrl.alu_func = alu_op_e'(ir_op[2:0]);
                ctrl.mdrsel   = MDR_ALU;
                state_next    = S_MDR2RA;
            end
            S_CMP: begin
                ctrl.rd_addr1 = ir_ra(ir);
                ctrl.rd_addr2 = ir_rb(ir);
                ctrl.a_write  = 1'b1;
                ctrl.b_write  = 1'b1;
                state_next    = S_CMP2;
            end
            S_CMP2: begin
                ctrl.alu_func = ALU_SUB;
                state_next    = S_CMP3;
            end
            S_CMP3: begin
                ctrl.alu_func  = ALU_SUB;
                ctrl.ccr_write = 1'b1;
                state_next     = S_FETCH;
            end
            S_BRANCH: begin
                ctrl.pcsel = br_taken ? PC_REL : PC_KEEP;
                state_next = S_FETCH;
            end
            S_LOAD: begin
                ctrl.rd_addr1 = ir_rb(ir);
                ctrl.a_write  = 1'b1;  // a <= rb
                state_next    = S_LOAD2;
            end
            S_LOAD2: begin
                ctrl.alu2sel = ALU2_SVAL;
                state_next   = S_LOAD3;
            end
            S_LOAD3: begin
                ctrl.alu2sel = ALU2_SVAL;
                ctrl.marsel  = MAR_ALU;  // mar <= rb + sval
                state_next   = S_LOADD;
            end
            S_LOADD: begin
                ctrl.addr_mar = 1'b1;
                ctrl.mdrsel   = MDR_BUS;
                bus_cyc       = 1'b1;
                if (bus_ack) begin
                    state_next = S_MDR2RA;
                end
            end
            S_STORE: begin
                ctrl.rd_addr1 = ir_rb(ir);
                ctrl.a_write  = 1'b1;  // a <= rb
                state_next    = S_STORE2;
            end
            S_STORE2: begin
                // address taken from old a while a reloads with ra
                ctrl.alu2sel  = ALU2_SVAL;
                ctrl.marsel   = MAR_ALU;
                ctrl.rd_addr1 = ir_ra(ir);
                ctrl.a_write  = 1'b1;
                state_next    = S_STORE3;
            end
            S_STORE3: begin
                ctrl.mdrsel = MDR_A;  // store data
                state_next  = S_STORE4;
            end
            S_STORE4: begin
                ctrl.addr_mar = 1'b1;
                bus_cyc       = 1'b1;
                bus_we        = 1'b1;
                if (bus_ack) begin
                    state_next = S_TERM;
                end
            end
            S_MDR2RA: begin
                ctrl.regsel    = REG_MDR;
                ctrl.reg_write = 1'b1;  // ra <= mdr
                state_next     = S_FETCH;
            end
            S_TERM:  state_next = S_FETCH;
            S_HALT:  state_next = S_HALT;
            default: state_next = S_HALT;
        endcase
    end

endmodule

`default_nettype wire

/* cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  word_t    bus_rdata,
    input  logic     bus_ack,
    output bus_req_t bus_req,
    output logic     halt
);

    ctrl_t  ctrl;
    word_t  ir;
    flags_t ccr;
    logic   bus_cyc;
    logic   bus_we;
    word_t  bus_adr;
    word_t  bus_wdat;

    cpu_control i_control (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .ir      (ir),
        .ccr     (ccr),
        .bus_ack (bus_ack),
        .ctrl    (ctrl),
        .bus_cyc (bus_cyc),
        .bus_we  (bus_we),
        .halt    (halt)
    );

    cpu_datapath #(
        .RESET_PC (RESET_PC)
    ) i_datapath (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .ctrl      (ctrl),
        .bus_rdata (bus_rdata),
        .bus_ack   (bus_ack),
        .ir        (ir),
        .ccr       (ccr),
        .bus_adr   (bus_adr),
        .bus_wdat  (bus_wdat)
    );

    assign bus_req = '{cyc: bus_cyc, we: bus_we, adr: bus_adr, dat: bus_wdat};

endmodule

`default_nettype wire

/* cpu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
    input logic clk_i,
    input logic rst_i,
    input logic bus_cyc,
    input logic bus_we,
    input logic bus_ack,
    input logic halt
);

    int assert_errors = 0;

    // request stays up until acked
    a_cyc_held: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (bus_cyc && !bus_ack) |=> (bus_cyc && $stable(bus_we))
    ) else begin
        $error("bus cycle dropped or changed before ack");
        assert_errors = assert_errors + 1;
    end

    a_halt_sticky: assert property (
        @(posedge clk_i) disable iff (rst_i)
        halt |=> halt
    ) else begin
        $error("halt fell without reset");
        assert_errors = assert_errors + 1;
    end

    a_halt_quiet: assert property (
        @(posedge clk_i) disable iff (rst_i)
        halt |-> !bus_cyc
    ) else begin
        $error("bus cycle raised while halted");
        assert_errors = assert_errors + 1;
    end

endmodule

bind cpu_control cpu_checker i_checker (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .bus_cyc (bus_cyc),
    .bus_we  (bus_we),
    .bus_ack (bus_ack),
    .halt    (halt)
);

`default_nettype wire

/* tb_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

    typedef struct packed {
        alu_op_e    op;
        word_t      x;
        word_t      y;
        branch_op_e br;
    } row_t;

    localparam int          NROWS    = 15;
    localparam word_t       BASE     = 32'h0000_0800;  // held in r5
    localparam int          X_DISP   = -256;
    localparam int          Y_DISP   = 64;
    localparam int          RES_DISP = 512;
    localparam int          FLG_DISP = 768;
    localparam int          TIMEOUT  = NROWS * 12 * 13 + 200;
    localparam logic [31:0] SEED     = 32'ha2b6_5ff3;

    localparam row_t ROWS [NROWS] = '{
        '{ALU_ADD, 32'h7fff_ffff, 32'h0000_0001, BEQ},
        '{ALU_SUB, 32'h0000_0005, 32'h0000_000a, BLT},
        '{ALU_AND, 32'hf0f0_1234, 32'h0ff0_ff00, BNE},
        '{ALU_OR,  32'h8000_0000, 32'h0000_0001, BLT},   // signed negative
        '{ALU_XOR, 32'h1234_5678, 32'h1234_5678, BEQ},
        '{ALU_SHL, 32'h0000_0003, 32'h0000_0024, BGEU},  // shift uses low 5 bits
        '{ALU_SHR, 32'h8000_0000, 32'h0000_001f, BLTU},
        '{ALU_SUB, 32'hffff_ffff, 32'h0000_0001, BGE},
        '{ALU_ADD, 32'hffff_ffff, 32'h0000_0002, BGEU},  // unsigned wrap
        '{ALU_SHL, 32'h8000_0001, 32'h0000_0001, BRA},
        '{ALU_SHR, 32'h0000_0010, 32'hffff_fff0, BLTU},
        '{ALU_OR,  32'hdead_beef, 32'hdead_beef, BGE},
        '{ALU_AND, 32'h8000_0000, 32'h7fff_ffff, BGEU},
        '{ALU_XOR, 32'h0000_0001, 32'h0000_0002, branch_op_e'(4'h3)},  // never
        '{ALU_SUB, 32'h0000_0042, 32'h0000_0042, BNE}
    };

    logic        clk_i;
    logic        rst_i;
    word_t       bus_rdata;
    logic        bus_ack;
    bus_req_t    bus_req;
    logic        halt;

    word_t       mem [1024];
    word_t       wr_adr [$];
    word_t       wr_dat [$];
    logic [31:0] lfsr_state;
    logic        busy;
    logic [1:0]  wait_left;
    logic [31:0] delay_bits;

    cpu_top #(
        .RESET_PC (32'h0)
    ) i_dut (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .bus_rdata (bus_rdata),
        .bus_ack   (bus_ack),
        .bus_req   (bus_req),
        .halt      (halt)
    );

    always #4 clk_i = ~clk_i;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int k = 0; k < n; k++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic word_t ldi_insn(input reg_addr_t ra, input logic [14:0] v);
        return {T_LDI, 4'h0, ra, 4'h0, v, 1'b0};
    endfunction

    function automatic word_t alu_insn(input alu_op_e op, input reg_addr_t ra,
                                       input reg_addr_t rb, input reg_addr_t rc);
        return {T_ALU, 1'b0, op, ra, rb, rc, 12'h000};
    endfunction

    function automatic word_t cmp_insn(input reg_addr_t ra, input reg_addr_t rb);
        return {T_CMP, 4'h0, ra, rb, 16'h0000};
    endfunction

    function automatic word_t branch_insn(input branch_op_e cond, input int disp);
        logic [31:0] d;
        d = disp;
        return {T_BRANCH, cond, 8'h00, d[14:0], 1'b0};
    endfunction

    function automatic word_t mem_insn(input itype_e t, input reg_addr_t ra,
                                       input reg_addr_t rb, input int disp);
        logic [31:0] d;
        d = disp;
        return {t, 4'h0, ra, rb, d[14:0], 1'b0};
    endfunction

    task automatic emit(inout int pc, input word_t insn);
        mem[pc] = insn;
        pc      = pc + 1;
    endtask

    task automatic build_program();
        int pc;
        pc = 0;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = ~(word_t'(i) * 32'h9e37_79b9);
        end
        emit(pc, ldi_insn(4'd5, BASE[14:0]));
        for (int r = 0; r < NROWS; r++) begin
            mem[(BASE + X_DISP + 4 * r) >> 2] = ROWS[r].x;
            mem[(BASE + Y_DISP + 4 * r) >> 2] = ROWS[r].y;
            emit(pc, mem_insn(T_LOAD, 4'd1, 4'd5, X_DISP + 4 * r));
            emit(pc, mem_insn(T_LOAD, 4'd2, 4'd5, Y_DISP + 4 * r));
            emit(pc, alu_insn(ROWS[r].op, 4'd3, 4'd1, 4'd2));
            emit(pc, mem_insn(T_STORE, 4'd3, 4'd5, RES_DISP + 4 * r));
            emit(pc, ldi_insn(4'd4, 15'd1));
            emit(pc, cmp_insn(4'd1, 4'd2));
            emit(pc, branch_insn(ROWS[r].br, 1));  // skips the next ldi
            emit(pc, ldi_insn(4'd4, 15'd2));
            emit(pc, mem_insn(T_STORE, 4'd4, 4'd5, FLG_DISP + 4 * r));
        end
        emit(pc, {T_INH, 4'h1, 24'h0});
    endtask

    function automatic word_t alu_expect(input alu_op_e op, input word_t x, input word_t y);
        case (op)
            ALU_ADD: return x + y;
            ALU_SUB: return x - y;
            ALU_AND: return x & y;
            ALU_OR:  return x | y;
            ALU_XOR: return x ^ y;
            ALU_SHL: return x << y[4:0];
            ALU_SHR: return x >> y[4:0];
            default: return 32'h0;
        endcase
    endfunction

    function automatic flags_t compare_flags(input word_t x, input word_t y);
        flags_t f;
        f.eq  = (x == y);
        f.lt  = ($signed(x) < $signed(y));
        f.ltu = (x < y);
        return f;
    endfunction

    function automatic logic branch_taken(input branch_op_e br, input flags_t f);
        case (br)
            BRA:     return 1'b1;
            BEQ:     return f.eq;
            BNE:     return !f.eq;
            BLT:     return f.lt;
            BGE:     return !f.lt;
            BLTU:    return f.ltu;
            BGEU:    return !f.ltu;
            default: return 1'b0;
        endcase
    endfunction

    // keeps only the flag that the condition looks at
    function automatic flags_t tested_flags(input branch_op_e br, input flags_t f);
        flags_t t;
        t = '0;
        case (br)
            BEQ, BNE:   t.eq = f.eq;
            BLT, BGE:   t.lt = f.lt;
            BLTU, BGEU: t.ltu = f.ltu;
            default:    t = '0;
        endcase
        return t;
    endfunction

    function automatic flags_t slot_flags(input branch_op_e br, input word_t slot);
        flags_t t;
        logic   taken;
        t     = '0;
        taken = (slot == 32'd1);
        case (br)
            BEQ:     t.eq = taken;
            BNE:     t.eq = !taken;
            BLT:     t.lt = taken;
            BGE:     t.lt = !taken;
            BLTU:    t.ltu = taken;
            BGEU:    t.ltu = !taken;
            default: t = '0;
        endcase
        return t;
    endfunction

    task automatic stop_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_flags(input string name, input flags_t got, input flags_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_results();
        flags_t f;
        word_t  flag_val;
        check_word("write count", word_t'(wr_adr.size()), word_t'(2 * NROWS));
        for (int r = 0; r < NROWS; r++) begin
            f        = compare_flags(ROWS[r].x, ROWS[r].y);
            flag_val = branch_taken(ROWS[r].br, f) ? 32'd1 : 32'd2;
            check_word($sformatf("bus_req.adr row %0d result", r), wr_adr[2 * r],
                       BASE + RES_DISP + 4 * r);
            check_word($sformatf("bus_req.dat row %0d result", r), wr_dat[2 * r],
                       alu_expect(ROWS[r].op, ROWS[r].x, ROWS[r].y));
            check_word($sformatf("bus_req.adr row %0d flag", r), wr_adr[2 * r + 1],
                       BASE + FLG_DISP + 4 * r);
            check_flags($sformatf("ccr row %0d", r), slot_flags(ROWS[r].br, wr_dat[2 * r + 1]),
                        tested_flags(ROWS[r].br, f));
            check_word($sformatf("bus_req.dat row %0d flag", r), wr_dat[2 * r + 1], flag_val);
        end
    endtask

    // bus slave with 0 to 3 wait cycles per access
    always @(posedge clk_i) begin
        #1;
        if (bus_ack) begin
            bus_ack = 1'b0;
            busy    = 1'b0;
        end else if (bus_req.cyc === 1'b1) begin
            if (!busy) begin
                busy = 1'b1;
                draw_bits(2, delay_bits);
                wait_left = delay_bits[1:0];
            end
            if (wait_left == 2'd0) begin
                if (bus_req.we) begin
                    mem[bus_req.adr[11:2]] = bus_req.dat;
                end else begin
                    bus_rdata = mem[bus_req.adr[11:2]];
                end
                bus_ack = 1'b1;
            end else begin
                wait_left = wait_left - 2'd1;
            end
        end
    end

    always @(negedge clk_i) begin
        if (bus_req.cyc === 1'b1 && bus_req.we === 1'b1 && bus_ack === 1'b1) begin
            wr_adr.push_back(bus_req.adr);
            wr_dat.push_back(bus_req.dat);
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        wait (rst_i === 1'b0);
        while (halt !== 1'b1) begin
            @(posedge clk_i);
            #1;
            cycles = cycles + 1;
            if (cycles > TIMEOUT) begin
                $display("timeout, halt never came within %0d cycles", TIMEOUT);
                stop_with_failure();
            end
        end
    end

    initial begin
        int halt_writes;
        clk_i      = 1'b0;
        rst_i      = 1'b1;
        bus_ack    = 1'b0;
        bus_rdata  = '0;
        busy       = 1'b0;
        wait_left  = 2'd0;
        lfsr_state = SEED;
        build_program();
        repeat (10) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        check_bit("halt", halt, 1'b0);
        check_bit("bus_req.cyc", bus_req.cyc, 1'b0);
        while (halt !== 1'b1) begin
            @(posedge clk_i);
            #1;
        end
        halt_writes = wr_adr.size();
        repeat (20) begin
            @(posedge clk_i);
            #1;
            check_bit("halt", halt, 1'b1);
            check_bit("bus_req.cyc", bus_req.cyc, 1'b0);
        end
        check_word("write count after halt", word_t'(wr_adr.size()), word_t'(halt_writes));
        check_results();
        if (i_dut.i_control.i_checker.assert_errors != 0) begin
            $display("bound assertions failed %0d times",
                     i_dut.i_control.i_checker.assert_errors);
            stop_with_failure();
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* filelist.f */
cpu_pkg.sv
cpu_alu.sv
cpu_datapath.sv
cpu_control.sv
cpu_top.sv
cpu_checker.sv
tb_cpu.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - cpu_pkg.sv
  - cpu_alu.sv
  - cpu_datapath.sv
  - cpu_control.sv
  - cpu_top.sv
  - target: simulation
    files:
      - cpu_checker.sv
      - tb_cpu.sv
